//--- tracer_config.svh
`ifndef TRACER_CONFIG_SVH
`define TRACER_CONFIG_SVH

// frame geometry, small default keeps simulation short
`define FRAME_WIDTH 32    // pixels per row
`define FRAME_HEIGHT 24   // rows per frame

// the eight neighbors of a pixel are read in one cycle, and every copy
// of the mask memory has two read ports, so four copies are needed
`define MASK_COPIES 4

`endif

//--- geom_pkg.sv
`include "tracer_config.svh"

package geom_pkg;

  // pixel position in the frame
  typedef logic [$clog2(`FRAME_WIDTH)-1:0] x_coord_t;    // column
  typedef logic [$clog2(`FRAME_HEIGHT)-1:0] y_coord_t;   // row

  // linear mask address, row * width + column
  typedef logic [$clog2(`FRAME_WIDTH * `FRAME_HEIGHT)-1:0] pix_addr_t;

  // perimeter in boundary steps, up to width * height + 1
  typedef logic [$clog2(`FRAME_WIDTH * `FRAME_HEIGHT + 2)-1:0] perim_t;

  // one bit per neighbor, indexed clockwise from up:
  // 0 up, 1 upright, 2 right, 3 downright,
  // 4 down, 5 downleft, 6 left, 7 upleft
  typedef logic [7:0] nbr_vec_t;

endpackage

//--- trace_ctrl_pkg.sv
package trace_ctrl_pkg;

  typedef enum logic [2:0] {
    IDLE,
    STORE,          // frame streaming into the mask copies
    SEARCH_ISSUE,   // raster probe address out
    SEARCH_CHECK,   // probe data back
    TRACE_ISSUE,    // neighbor addresses out
    TRACE_STEP,     // neighbor bits back, move
    DONE
  } tracer_state_e;

  // side the tracer entered the current pixel from
  typedef enum logic [1:0] {FROM_UP, FROM_RIGHT, FROM_DOWN, FROM_LEFT} from_dir_e;

  // move directions in clockwise order, same order as nbr_vec_t bits
  typedef enum logic [2:0] {
    STEP_UP, STEP_UPRIGHT, STEP_RIGHT, STEP_DOWNRIGHT,
    STEP_DOWN, STEP_DOWNLEFT, STEP_LEFT, STEP_UPLEFT
  } step_dir_e;

  typedef struct packed {
    logic      valid;      // some neighbor was set
    step_dir_e dir;
    from_dir_e new_from;   // arrival side after the move
  } step_t;

endpackage

//--- frame_if.sv
interface frame_if import geom_pkg::*; ();

  x_coord_t scan_x;      // pixel under test or trace center
  y_coord_t scan_y;
  logic     trace_mode;  // 1 reads the eight neighbors, 0 reads the pixel itself

  logic     center_bit;  // mask bit at last cycle's scan position
  nbr_vec_t nbr_bits;    // neighbors of last cycle's position, off-frame as 0

  // controller side
  modport ctrl (
    output scan_x,
    output scan_y,
    output trace_mode,
    input  center_bit
  );

  // mask memory side
  modport store (
    input  scan_x,
    input  scan_y,
    input  trace_mode,
    output center_bit,
    output nbr_bits
  );

endinterface

//--- mask_ram.sv
`include "tracer_config.svh"

module mask_ram import geom_pkg::*; (
  input  logic      clk_in,
  input  logic      we,
  input  pix_addr_t addr_a,
  input  pix_addr_t addr_b,
  input  logic      wdata,
  output logic      rdata_a,
  output logic      rdata_b
);

  logic mem [`FRAME_WIDTH * `FRAME_HEIGHT];   // one bit per pixel

  // port a writes and reads, read returns the old contents
  always_ff @(posedge clk_in) begin
    if (we) begin
      mem[addr_a] <= wdata;
    end
    rdata_a <= mem[addr_a];
  end

  // port b is read only
  always_ff @(posedge clk_in) begin
    rdata_b <= mem[addr_b];
  end

endmodule

//--- frame_store.sv
`include "tracer_config.svh"

module frame_store import geom_pkg::*; (
  input  logic     clk_in,
  frame_if.store   fb,
  input  logic     we,
  input  x_coord_t pixel_x,
  input  y_coord_t pixel_y,
  input  logic     pixel_masked
);

  // neighbor offsets in nbr_vec_t order
  localparam int DX [8] = '{0, 1, 1, 1, 0, -1, -1, -1};
  localparam int DY [8] = '{-1, -1, 0, 1, 1, 1, 0, -1};

  pix_addr_t wr_addr;
  pix_addr_t scan_addr;
  pix_addr_t nbr_addr [8];
  logic [7:0] in_frame;      // neighbor lies inside the frame
  logic [7:0] in_frame_q;    // aligned with the memory read data
  logic [7:0] raw;           // memory outputs before edge masking

  assign wr_addr = pix_addr_t'(int'(pixel_y) * `FRAME_WIDTH + int'(pixel_x));
  assign scan_addr = pix_addr_t'(int'(fb.scan_y) * `FRAME_WIDTH + int'(fb.scan_x));

  // neighbor addresses, off-frame ones parked at 0 and masked later
  always_comb begin
    int nx;
    int ny;
    for (int d = 0; d < 8; d++) begin
      nx = int'(fb.scan_x) + DX[d];
      ny = int'(fb.scan_y) + DY[d];
      in_frame[d] = (nx >= 0) && (nx < `FRAME_WIDTH) && (ny >= 0) && (ny < `FRAME_HEIGHT);
      nbr_addr[d] = in_frame[d] ? pix_addr_t'(ny * `FRAME_WIDTH + nx) : '0;
    end
  end

  always_ff @(posedge clk_in) begin
    in_frame_q <= in_frame;
  end

  // copy i serves neighbors 2i on port a and 2i+1 on port b
  // outside trace mode port a carries the write, port b the scan pixel
  for (genvar i = 0; i < `MASK_COPIES; i++) begin : g_copy
    mask_ram ram_i (
      .clk_in  (clk_in),
      .we      (we),
      .addr_a  (fb.trace_mode ? nbr_addr[2*i] : wr_addr),
      .addr_b  (fb.trace_mode ? nbr_addr[2*i+1] : scan_addr),
      .wdata   (pixel_masked),
      .rdata_a (raw[2*i]),
      .rdata_b (raw[2*i+1])
    );
  end

  assign fb.center_bit = raw[1];          // copy 0 port b in scan mode
  assign fb.nbr_bits = raw & in_frame_q;  // off-frame reads as 0

endmodule

//--- moore_step.sv
module moore_step import geom_pkg::*; import trace_ctrl_pkg::*; (
  input  from_dir_e from_dir,
  input  nbr_vec_t  nbr_bits,
  output step_t     step
);

  // side the tracer enters from after taking a move
  function automatic from_dir_e arrival_after(step_dir_e dir);
    case (dir)
      STEP_UP, STEP_UPRIGHT:      arrival_after = FROM_LEFT;
      STEP_RIGHT, STEP_DOWNRIGHT: arrival_after = FROM_UP;
      STEP_DOWN, STEP_DOWNLEFT:   arrival_after = FROM_RIGHT;
      STEP_LEFT, STEP_UPLEFT:     arrival_after = FROM_DOWN;
    endcase
  endfunction

  logic [2:0] first_idx;   // highest priority neighbor

  // priority list starts at the neighbor on the arrival side and goes
  // clockwise, so up starts at 0, right at 2, down at 4, left at 6
  assign first_idx = {from_dir, 1'b0};

  always_comb begin
    logic [2:0] idx;
    logic       found;
    found = 1'b0;
    step.dir = STEP_UP;
    for (int k = 0; k < 8; k++) begin
      idx = 3'(first_idx + k);   // wraps past upleft
      if (!found && nbr_bits[idx]) begin
        found = 1'b1;
        step.dir = step_dir_e'(idx);
      end
    end
    step.valid = found;          // no move on an isolated pixel
    step.new_from = arrival_after(step.dir);
  end

endmodule

//--- trace_controller.sv
`include "tracer_config.svh"

module trace_controller import geom_pkg::*; import trace_ctrl_pkg::*; (
  input  logic      clk_in,
  input  logic      rst_in,
  input  logic      frame_start,
  input  logic      pixel_valid,
  input  x_coord_t  pixel_x,
  input  y_coord_t  pixel_y,
  frame_if.ctrl     fb,
  input  step_t     step,
  output from_dir_e from_dir,
  output logic      store_active,
  output perim_t    perimeter,
  output logic      busy,
  output logic      done
);

  tracer_state_e state;
  x_coord_t      start_x;         // first set pixel of the raster scan
  y_coord_t      start_y;
  logic          trace_started;   // at least one trace step taken
  logic          at_start;
  logic          last_scan;       // scan at the bottom right pixel
  logic          last_pixel;      // final pixel of the frame streaming in
  x_coord_t      next_x;          // scan position after the chosen move
  y_coord_t      next_y;

  assign at_start = (fb.scan_x == start_x) && (fb.scan_y == start_y);
  assign last_scan = (fb.scan_x == x_coord_t'(`FRAME_WIDTH - 1)) &&
                     (fb.scan_y == y_coord_t'(`FRAME_HEIGHT - 1));
  assign last_pixel = pixel_valid && (pixel_x == x_coord_t'(`FRAME_WIDTH - 1)) &&
                      (pixel_y == y_coord_t'(`FRAME_HEIGHT - 1));

  assign store_active = (state == STORE);
  assign fb.trace_mode = (state == TRACE_ISSUE) || (state == TRACE_STEP);
  assign busy = (state != IDLE) && (state != DONE);
  assign done = (state == DONE);   // one cycle, DONE always returns to IDLE

  always_comb begin
    case (step.dir)
      STEP_UPRIGHT, STEP_RIGHT, STEP_DOWNRIGHT: next_x = fb.scan_x + 1'b1;
      STEP_DOWNLEFT, STEP_LEFT, STEP_UPLEFT:    next_x = fb.scan_x - 1'b1;
      STEP_UP, STEP_DOWN:                       next_x = fb.scan_x;
    endcase
    case (step.dir)
      STEP_UPLEFT, STEP_UP, STEP_UPRIGHT:       next_y = fb.scan_y - 1'b1;
      STEP_DOWNRIGHT, STEP_DOWN, STEP_DOWNLEFT: next_y = fb.scan_y + 1'b1;
      STEP_RIGHT, STEP_LEFT:                    next_y = fb.scan_y;
    endcase
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state <= IDLE;
      from_dir <= FROM_UP;
      trace_started <= 1'b0;
      perimeter <= '0;
      fb.scan_x <= '0;
      fb.scan_y <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (frame_start) begin
            state <= STORE;
            perimeter <= '0;   // old result dropped on a new frame
          end
        end
        STORE: begin
          if (last_pixel) begin
            state <= SEARCH_ISSUE;
            fb.scan_x <= '0;
            fb.scan_y <= '0;
          end
        end
        SEARCH_ISSUE: state <= SEARCH_CHECK;
        SEARCH_CHECK: begin
          if (fb.center_bit) begin
            state <= TRACE_ISSUE;
            perimeter <= perim_t'(1);   // start pixel counts once
            from_dir <= FROM_UP;
            trace_started <= 1'b0;
          end else if (last_scan) begin
            state <= DONE;               // empty frame
            perimeter <= '0;
          end else begin
            state <= SEARCH_ISSUE;
            if (fb.scan_x == x_coord_t'(`FRAME_WIDTH - 1)) begin
              fb.scan_x <= '0;
              fb.scan_y <= fb.scan_y + 1'b1;
            end else begin
              fb.scan_x <= fb.scan_x + 1'b1;
            end
          end
        end
        TRACE_ISSUE: state <= TRACE_STEP;
        TRACE_STEP: begin
          if (!at_start) begin
            perimeter <= perimeter + 1'b1;
          end
          if (trace_started && at_start) begin
            state <= DONE;               // back on the start pixel
          end else begin
            state <= TRACE_ISSUE;
            trace_started <= 1'b1;
            if (step.valid) begin
              fb.scan_x <= next_x;
              fb.scan_y <= next_y;
              from_dir <= step.new_from;
            end
          end
        end
        DONE: state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // start pixel, captured when the search finds it
  always_ff @(posedge clk_in) begin
    if ((state == SEARCH_CHECK) && fb.center_bit) begin
      start_x <= fb.scan_x;
      start_y <= fb.scan_y;
    end
  end

endmodule

//--- contour_tracer_top.sv
module contour_tracer_top import geom_pkg::*; import trace_ctrl_pkg::*; (
  input  logic     clk_in,
  input  logic     rst_in,
  input  logic     frame_start,
  input  logic     pixel_valid,
  input  logic     pixel_masked,
  input  x_coord_t pixel_x,
  input  y_coord_t pixel_y,
  output perim_t   perimeter,
  output logic     busy,
  output logic     done
);

  frame_if   fb_if ();
  step_t     step;
  from_dir_e from_dir;
  logic      store_active;

  trace_controller ctrl_i (
    .clk_in       (clk_in),
    .rst_in       (rst_in),
    .frame_start  (frame_start),
    .pixel_valid  (pixel_valid),
    .pixel_x      (pixel_x),
    .pixel_y      (pixel_y),
    .fb           (fb_if.ctrl),
    .step         (step),
    .from_dir     (from_dir),
    .store_active (store_active),
    .perimeter    (perimeter),
    .busy         (busy),
    .done         (done)
  );

  frame_store store_i (
    .clk_in       (clk_in),
    .fb           (fb_if.store),
    .we           (pixel_valid & store_active),   // pixels outside STORE dropped
    .pixel_x      (pixel_x),
    .pixel_y      (pixel_y),
    .pixel_masked (pixel_masked)
  );

  moore_step step_i (
    .from_dir (from_dir),
    .nbr_bits (fb_if.nbr_bits),
    .step     (step)
  );

endmodule

//--- tb_contour_tracer.sv
`include "tracer_config.svh"

module tb_contour_tracer import geom_pkg::*; import trace_ctrl_pkg::*; ();

  localparam int W = `FRAME_WIDTH;
  localparam int H = `FRAME_HEIGHT;
  localparam int PIX = W * H;
  localparam int NUM_FRAMES = 12;
  localparam int TIMEOUT_CYCLES = NUM_FRAMES * 3 * PIX + 4 * PIX + 500;

  // neighbor priority rows for arrival from up, right, down and left
  localparam int PRIO [4][8] = '{'{0, 1, 2, 3, 4, 5, 6, 7},
                                 '{2, 3, 4, 5, 6, 7, 0, 1},
                                 '{4, 5, 6, 7, 0, 1, 2, 3},
                                 '{6, 7, 0, 1, 2, 3, 4, 5}};
  localparam int DX [8] = '{0, 1, 1, 1, 0, -1, -1, -1};   // clockwise from up
  localparam int DY [8] = '{-1, -1, 0, 1, 1, 1, 0, -1};

  logic     clk_in;
  logic     rst_in;
  logic     frame_start;
  logic     pixel_valid;
  logic     pixel_masked;
  x_coord_t pixel_x;
  y_coord_t pixel_y;
  perim_t   perimeter;
  logic     busy;
  logic     done;

  logic        img [H][W];         // frame image streamed to the DUT
  logic [31:0] lcg_state = 32'h3d;
  perim_t      exp_perim;          // expected value for the next done pulse
  int          errors = 0;
  int          tests_run = 0;
  int          done_seen = 0;
  int          cycles = 0;

  contour_tracer_top dut_i (
    .clk_in       (clk_in),
    .rst_in       (rst_in),
    .frame_start  (frame_start),
    .pixel_valid  (pixel_valid),
    .pixel_masked (pixel_masked),
    .pixel_x      (pixel_x),
    .pixel_y      (pixel_y),
    .perimeter    (perimeter),
    .busy         (busy),
    .done         (done)
  );

  initial clk_in = 1'b0;
  always #50 clk_in = ~clk_in;

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic int rand_below(input int n);
    return int'(next_random() >> 16) % n;
  endfunction

  function automatic void clear_image();
    for (int y = 0; y < H; y++) begin
      for (int x = 0; x < W; x++) begin
        img[y][x] = 1'b0;
      end
    end
  endfunction

  function automatic void add_rect(input int x0, input int y0, input int w, input int h);
    for (int y = y0; y < y0 + h; y++) begin
      for (int x = x0; x < x0 + w; x++) begin
        img[y][x] = 1'b1;
      end
    end
  endfunction

  function automatic logic pixel_at(input int x, input int y);
    if (x < 0 || x >= W || y < 0 || y >= H) begin
      return 1'b0;   // off-frame neighbor
    end
    return img[y][x];
  endfunction

  function automatic from_dir_e arrival_for(input int d);
    case (d)
      0, 1:    return FROM_LEFT;
      2, 3:    return FROM_UP;
      4, 5:    return FROM_RIGHT;
      default: return FROM_DOWN;
    endcase
  endfunction

  // raster search followed by Moore tracing with the step count rule
  function automatic perim_t ref_perimeter();
    int        sx;
    int        sy;
    int        cx;
    int        cy;
    int        d;
    int        count;
    logic      started;
    logic      moved;
    from_dir_e arrive;
    sx = -1;
    sy = -1;
    for (int y = 0; y < H; y++) begin
      for (int x = 0; x < W; x++) begin
        if (sx < 0 && img[y][x]) begin
          sx = x;
          sy = y;
        end
      end
    end
    if (sx < 0) begin
      return '0;
    end
    cx = sx;
    cy = sy;
    arrive = FROM_UP;
    count = 1;
    started = 1'b0;
    for (int n = 0; n < PIX; n++) begin
      if (cx != sx || cy != sy) begin
        count++;
      end else if (started) begin
        break;
      end
      started = 1'b1;
      moved = 1'b0;
      for (int k = 0; k < 8 && !moved; k++) begin
        d = PRIO[int'(arrive)][k];
        if (pixel_at(cx + DX[d], cy + DY[d])) begin
          moved = 1'b1;
          cx = cx + DX[d];
          cy = cy + DY[d];
          arrive = arrival_for(d);
        end
      end
    end
    return perim_t'(count);
  endfunction

  task automatic check_perim(input perim_t got, input perim_t exp, input string what);
    if (got !== exp) begin
      $display("FAIL at time %0t: %s, perimeter %0d expected %0d", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_flags(input logic got_done, input logic got_busy,
                             input logic exp_done, input logic exp_busy, input string what);
    if (got_done !== exp_done || got_busy !== exp_busy) begin
      $display("FAIL at time %0t: %s, done %b busy %b expected done %b busy %b",
               $time, what, got_done, got_busy, exp_done, exp_busy);
      errors++;
    end
  endtask

  // perimeter checked on every done pulse
  always @(negedge clk_in) begin
    if (!rst_in && done) begin
      done_seen++;
      check_perim(perimeter, exp_perim, "perimeter at done");
    end
  end

  always @(posedge clk_in) begin
    cycles++;
    if (cycles > TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Test failures found");
      $finish;
    end
  end

  // streams the image in raster order with optional idle gaps and a stray frame_start
  task automatic stream_image(input int count, input logic gaps, input int restart_at,
                              input logic exp_busy);
    for (int i = 0; i < count; i++) begin
      if (gaps && rand_below(4) == 0) begin
        pixel_valid = 1'b0;
        frame_start = 1'b0;
        check_flags(done, busy, 1'b0, exp_busy, "flags during idle gap");
        @(negedge clk_in);
      end
      check_flags(done, busy, 1'b0, exp_busy, "flags while streaming");
      pixel_valid = 1'b1;
      pixel_x = x_coord_t'(i % W);
      pixel_y = y_coord_t'(i / W);
      pixel_masked = img[i / W][i % W];
      frame_start = (i == restart_at);
      @(negedge clk_in);
    end
    pixel_valid = 1'b0;
    frame_start = 1'b0;
  endtask

  task automatic run_frame(input string name, input perim_t expected, input logic gaps,
                           input int restart_at);
    int errs_before;
    int seen_before;
    errs_before = errors;
    seen_before = done_seen;
    exp_perim = expected;
    frame_start = 1'b1;
    @(negedge clk_in);
    frame_start = 1'b0;
    stream_image(PIX, gaps, restart_at, 1'b1);
    if (restart_at >= 0) begin
      frame_start = 1'b1;   // lands in search and must be ignored
      @(negedge clk_in);
      frame_start = 1'b0;
    end
    while (!done) begin
      check_flags(done, busy, 1'b0, 1'b1, "busy until done");
      @(negedge clk_in);
    end
    check_flags(done, busy, 1'b1, 1'b0, "busy low with done");
    @(negedge clk_in);
    check_flags(done, busy, 1'b0, 1'b0, "cycle after done");
    check_perim(perimeter, expected, "perimeter held after done");
    if (done_seen != seen_before + 1) begin
      $display("error: %s gave %0d done pulses instead of one", name, done_seen - seen_before);
      errors++;
    end
    tests_run++;
    $display("test %s: %s", name, (errors == errs_before) ? "ok" : "FAILED");
  endtask

  initial begin
    int w;
    int h;
    rst_in = 1'b1;
    frame_start = 1'b0;
    pixel_valid = 1'b0;
    pixel_masked = 1'b0;
    pixel_x = '0;
    pixel_y = '0;
    repeat (5) @(negedge clk_in);
    rst_in = 1'b0;

    check_flags(done, busy, 1'b0, 1'b0, "after reset");
    check_perim(perimeter, '0, "after reset");
    clear_image();
    add_rect(0, 0, 8, 2);
    stream_image(40, 1'b0, -1, 1'b0);   // all dropped without frame_start
    check_flags(done, busy, 1'b0, 1'b0, "stray pixels in idle");
    check_perim(perimeter, '0, "stray pixels in idle");
    tests_run++;
    $display("test reset and idle pixels: %s", (errors == 0) ? "ok" : "FAILED");

    clear_image();
    run_frame("empty frame", perim_t'(0), 1'b0, -1);
    img[10][12] = 1'b1;
    run_frame("lone interior pixel", perim_t'(1), 1'b0, -1);
    clear_image();
    img[H-1][W-1] = 1'b1;
    run_frame("lone corner pixel", perim_t'(1), 1'b0, -1);

    clear_image();
    add_rect(8, 6, 5, 4);
    run_frame("interior rectangle", ref_perimeter(), 1'b0, -1);
    clear_image();
    add_rect(0, 0, 6, 3);   // top and left edges
    run_frame("corner rectangle", ref_perimeter(), 1'b0, -1);
    clear_image();
    add_rect(0, H - 2, W, 2);   // full width bottom bar
    run_frame("bottom bar", ref_perimeter(), 1'b0, -1);
    clear_image();
    add_rect(W - 4, 0, 4, 12);
    add_rect(W - 12, 9, 8, 3);
    run_frame("edge L shape", ref_perimeter(), 1'b0, -1);

    for (int r = 0; r < 4; r++) begin
      clear_image();
      w = 1 + rand_below(10);
      h = 1 + rand_below(8);
      add_rect(rand_below(W - w + 1), rand_below(H - h + 1), w, h);
      run_frame($sformatf("random rectangle %0d", r), ref_perimeter(), 1'b1, -1);
    end

    clear_image();
    w = 2 + rand_below(8);
    h = 2 + rand_below(6);
    add_rect(rand_below(W - w + 1), rand_below(H - h + 1), w, h);
    run_frame("frame_start while busy", ref_perimeter(), 1'b0, PIX / 2);

    $display("tests run %0d, errors %0d", tests_run, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- project.f
+incdir+.
geom_pkg.sv
trace_ctrl_pkg.sv
frame_if.sv
mask_ram.sv
frame_store.sv
moore_step.sv
trace_controller.sv
contour_tracer_top.sv
tb_contour_tracer.sv

//--- run_sim.sh
#!/bin/sh
# build the contour tracer testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f project.f --top-module tb_contour_tracer \
  -o sim_contour_tracer > build.log 2>&1 &&
./obj_dir/sim_contour_tracer > sim.log 2>&1 ||
{ echo "build or simulation failed, see build.log and sim.log"; exit 1; }
cat sim.log &&
grep -q "All tests passed!" sim.log &&
echo "simulation PASS" ||
{ echo "simulation FAIL"; exit 1; }
